// ==== design/queue_ctrl_pkg.sv ====
package queue_ctrl_pkg;

    // slot count, the field layout and the test data assume 8
    localparam int queue_depth = 8;
    localparam int ptr_width   = $clog2(queue_depth);

    // occupancy has to reach queue_depth itself
    localparam int cnt_width   = ptr_width + 1;

    typedef logic [ptr_width-1:0]   slot_t;
    typedef logic [queue_depth-1:0] slot_mask_t;

    // what the controller does at the coming edge
    typedef enum logic [2:0] {
        op_idle     = 3'd0,
        op_push     = 3'd1,
        op_pop      = 3'd2,
        op_push_pop = 3'd3,
        op_clear    = 3'd4
    } queue_op_e;

endpackage

// ==== design/latch_fields_pkg.sv ====
package latch_fields_pkg;

    // operand value is one machine word
    localparam int op_val_width = 32;

    // modifiable part widths
    localparam int wake_width   = 4;
    localparam int ptc_id_width = 5;

    // fixed part widths
    localparam int eip_width    = 32;
    localparam int addr_width   = 32;
    localparam int opsize_width = 2;
    localparam int aluk_width   = 5;

    // alu opcode as carried to execute
    typedef enum logic [aluk_width-1:0] {
        alu_add  = 5'd0,
        alu_sub  = 5'd1,
        alu_and  = 5'd2,
        alu_or   = 5'd3,
        alu_xor  = 5'd4,
        alu_shl  = 5'd5,
        alu_shr  = 5'd6,
        alu_pass = 5'd7
    } alu_op_e;

    // rewritten in place by forwarding while the entry waits
    typedef struct packed {
        logic [wake_width-1:0]   wake;
        logic [ptc_id_width-1:0] ptc_id;
        logic [op_val_width-1:0] op1_val;
        logic [op_val_width-1:0] op2_val;
        logic                    valid;
    } mod_fields_t;

    // written once at push
    typedef struct packed {
        logic [eip_width-1:0]    eip;
        alu_op_e                 aluk;
        logic [opsize_width-1:0] opsize;
        logic [addr_width-1:0]   dest_addr;
        logic                    is_br;
    } fixed_fields_t;

    // queue output word, modifiable part in the upper bits
    typedef struct packed {
        mod_fields_t   mod_part;
        fixed_fields_t fixed_part;
    } latch_entry_t;

    // one modifiable record per slot, slot 0 in the low bits
    typedef mod_fields_t [queue_ctrl_pkg::queue_depth-1:0] mod_vector_t;

endpackage

// ==== design/queue_ctrl.sv ====
`timescale 1ns/1ps

module queue_ctrl (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  wr,
    input  logic                  rd,
    input  logic                  clr,
    output logic                  full,
    output logic                  empty,
    output logic                  push_en,
    output logic                  pop_en,
    output queue_ctrl_pkg::slot_t wr_slot,
    output queue_ctrl_pkg::slot_t rd_slot
);
    import queue_ctrl_pkg::*;

    logic [cnt_width-1:0] count;
    slot_t                wr_ptr;
    slot_t                rd_ptr;
    queue_op_e            q_op;

    // wrap at the last slot
    // depth need not be a power of two
    function automatic slot_t next_slot(input slot_t s);
        if (s == slot_t'(queue_depth - 1)) begin
            return '0;
        end
        return s + slot_t'(1);
    endfunction

    // flags straight off the registered count
    assign full  = (count == cnt_width'(queue_depth));
    assign empty = (count == '0);

    // full drops a wr even with rd high
    // clr beats both
    assign push_en = wr && !full && !clr;
    assign pop_en  = rd && !empty && !clr;

    assign wr_slot = wr_ptr;
    assign rd_slot = rd_ptr;

    always_comb begin
        if (clr) begin
            q_op = op_clear;
        end else if (push_en && pop_en) begin
            q_op = op_push_pop;
        end else if (push_en) begin
            q_op = op_push;
        end else if (pop_en) begin
            q_op = op_pop;
        end else begin
            q_op = op_idle;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            unique case (q_op)
                op_clear: begin
                    wr_ptr <= '0;
                    rd_ptr <= '0;
                    count  <= '0;
                end
                op_push: begin
                    wr_ptr <= next_slot(wr_ptr);
                    count  <= count + cnt_width'(1);
                end
                op_pop: begin
                    rd_ptr <= next_slot(rd_ptr);
                    count  <= count - cnt_width'(1);
                end
                // occupancy unchanged, both pointers move
                op_push_pop: begin
                    wr_ptr <= next_slot(wr_ptr);
                    rd_ptr <= next_slot(rd_ptr);
                end
                op_idle: begin
                    count <= count;
                end
            endcase
        end
    end

    a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
        count <= cnt_width'(queue_depth))
        else $error("queue_ctrl: occupancy %0d above depth", count);

    // no write pointer step out of a full queue
    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
        full && !clr |=> $stable(wr_ptr))
        else $error("queue_ctrl: push accepted while full");

    // no read pointer step out of an empty queue
    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
        empty && !clr |=> $stable(rd_ptr))
        else $error("queue_ctrl: pop accepted while empty");

endmodule

// ==== design/mod_field_bank.sv ====
`timescale 1ns/1ps

module mod_field_bank (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          push_en,
    input  queue_ctrl_pkg::slot_t         wr_slot,
    input  latch_fields_pkg::mod_fields_t m_din,
    input  queue_ctrl_pkg::slot_mask_t    modify_mask,
    input  latch_fields_pkg::mod_vector_t new_m_vector,
    input  queue_ctrl_pkg::slot_t         rd_slot,
    output latch_fields_pkg::mod_fields_t rd_m,
    output latch_fields_pkg::mod_vector_t old_m_vector
);
    import queue_ctrl_pkg::*;
    import latch_fields_pkg::*;

    // whole bank as one packed vector, shown outside as is
    mod_vector_t slots_q;

    // per-slot views for the write select and the check
    slot_mask_t  stored_valid;
    slot_mask_t  push_hit;

    always_comb begin
        for (int i = 0; i < queue_depth; i++) begin
            stored_valid[i] = slots_q[i].valid;
            push_hit[i]     = push_en && (wr_slot == slot_t'(i));
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // only the valid bits, payload is don't-care
            for (int i = 0; i < queue_depth; i++) begin
                slots_q[i].valid <= 1'b0;
            end
        end else begin
            for (int i = 0; i < queue_depth; i++) begin
                // push beats a same-edge modification
                if (push_hit[i]) begin
                    slots_q[i] <= m_din;
                end else if (modify_mask[i]) begin
                    slots_q[i] <= new_m_vector[i];
                end
            end
        end
    end

    // read before the edge, so a same-edge pop sees the old record
    assign rd_m         = slots_q[rd_slot];
    assign old_m_vector = slots_q;

    // forwarding only rewrites live entries
    // the slot being pushed this edge is exempt
    a_mod_live: assert property (@(posedge clk) disable iff (!rst_n)
        (modify_mask & ~push_hit & ~stored_valid) == '0)
        else $error("mod_field_bank: modify mask %b hits invalid slots %b",
                    modify_mask, ~stored_valid);

endmodule

// ==== design/fixed_field_bank.sv ====
`timescale 1ns/1ps

module fixed_field_bank (
    input  logic                            clk,
    input  logic                            push_en,
    input  queue_ctrl_pkg::slot_t           wr_slot,
    input  latch_fields_pkg::fixed_fields_t n_din,
    input  queue_ctrl_pkg::slot_t           rd_slot,
    output latch_fields_pkg::fixed_fields_t rd_n
);
    import queue_ctrl_pkg::*;
    import latch_fields_pkg::*;

    // one fixed record per slot
    fixed_fields_t slots_q [queue_depth];

    // written at push only, never touched by forwarding
    always_ff @(posedge clk) begin
        if (push_en) begin
            slots_q[wr_slot] <= n_din;
        end
    end

    // combinational read, merge stage registers it
    assign rd_n = slots_q[rd_slot];

endmodule

// ==== design/entry_merge.sv ====
`timescale 1ns/1ps

module entry_merge (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            pop_en,
    input  latch_fields_pkg::mod_fields_t   rd_m,
    input  latch_fields_pkg::fixed_fields_t rd_n,
    output latch_fields_pkg::latch_entry_t  dout,
    output logic                            dout_valid
);
    import latch_fields_pkg::*;

    // high for the one cycle after each pop
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dout_valid <= 1'b0;
        end else begin
            dout_valid <= pop_en;
        end
    end

    // join both halves of the popped slot
    // held between pops
    always_ff @(posedge clk) begin
        if (pop_en) begin
            dout.mod_part   <= rd_m;
            dout.fixed_part <= rd_n;
        end
    end

    // a pop must hand execute a live entry
    a_pop_valid: assert property (@(posedge clk) disable iff (!rst_n)
        pop_en |=> dout.mod_part.valid)
        else $error("entry_merge: popped entry has valid clear");

endmodule

// ==== design/mem_ex_queue_top.sv ====
`timescale 1ns/1ps

module mem_ex_queue_top (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            wr,
    input  logic                            rd,
    input  logic                            clr,
    input  latch_fields_pkg::mod_fields_t   m_din,
    input  latch_fields_pkg::fixed_fields_t n_din,
    input  queue_ctrl_pkg::slot_mask_t      modify_mask,
    input  latch_fields_pkg::mod_vector_t   new_m_vector,
    output logic                            full,
    output logic                            empty,
    output latch_fields_pkg::mod_vector_t   old_m_vector,
    output latch_fields_pkg::latch_entry_t  dout,
    output logic                            dout_valid
);
    import queue_ctrl_pkg::*;
    import latch_fields_pkg::*;

    logic          push_en;
    logic          pop_en;
    slot_t         wr_slot;
    slot_t         rd_slot;
    mod_fields_t   rd_m;
    fixed_fields_t rd_n;

    // pointers and handshake
    queue_ctrl i_queue_ctrl (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr      (wr),
        .rd      (rd),
        .clr     (clr),
        .full    (full),
        .empty   (empty),
        .push_en (push_en),
        .pop_en  (pop_en),
        .wr_slot (wr_slot),
        .rd_slot (rd_slot)
    );

    // both banks share the same slot indices
    mod_field_bank i_mod_bank (
        .clk          (clk),
        .rst_n        (rst_n),
        .push_en      (push_en),
        .wr_slot      (wr_slot),
        .m_din        (m_din),
        .modify_mask  (modify_mask),
        .new_m_vector (new_m_vector),
        .rd_slot      (rd_slot),
        .rd_m         (rd_m),
        .old_m_vector (old_m_vector)
    );

    fixed_field_bank i_fixed_bank (
        .clk     (clk),
        .push_en (push_en),
        .wr_slot (wr_slot),
        .n_din   (n_din),
        .rd_slot (rd_slot),
        .rd_n    (rd_n)
    );

    // registered output toward execute
    entry_merge i_entry_merge (
        .clk        (clk),
        .rst_n      (rst_n),
        .pop_en     (pop_en),
        .rd_m       (rd_m),
        .rd_n       (rd_n),
        .dout       (dout),
        .dout_valid (dout_valid)
    );

endmodule

// ==== bench/tb_mem_ex_queue.sv ====
`timescale 1ns/1ps

module tb_mem_ex_queue;
    import latch_fields_pkg::*;
    import queue_ctrl_pkg::*;

    localparam int clk_period  = 100;
    localparam int reset_limit = 16;
    localparam int line_limit  = 500;
    localparam int n_cols      = 21;

    logic          clk;
    logic          rst_n;
    logic          wr;
    logic          rd;
    logic          clr;
    mod_fields_t   m_din;
    fixed_fields_t n_din;
    slot_mask_t    modify_mask;
    mod_vector_t   new_m_vector;
    logic          full;
    logic          empty;
    mod_vector_t   old_m_vector;
    latch_entry_t  dout;
    logic          dout_valid;

    int checks;
    int value_errs;
    int other_errs;

    // raw text of one data line, then its columns
    logic [8*160-1:0] line_buf;
    logic [7:0] c_wr, c_rd, c_clr, c_mask, c_mt, c_nt;
    logic [7:0] c_nv [queue_depth];
    logic [7:0] e_full, e_empty, e_dv, e_mt, e_nt, e_osl, e_otag;

    mem_ex_queue_top i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .wr           (wr),
        .rd           (rd),
        .clr          (clr),
        .m_din        (m_din),
        .n_din        (n_din),
        .modify_mask  (modify_mask),
        .new_m_vector (new_m_vector),
        .full         (full),
        .empty        (empty),
        .old_m_vector (old_m_vector),
        .dout         (dout),
        .dout_valid   (dout_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // tag to full modifiable record, tag 00 is an empty record
    function automatic mod_fields_t expand_mod(input logic [7:0] t);
        mod_fields_t m;
        m.wake    = t[7:4];
        m.ptc_id  = t[4:0];
        m.op1_val = {4{t}};
        m.op2_val = {t, ~t, t, ~t};
        m.valid   = (t != 8'h00);
        return m;
    endfunction

    // tag to full fixed record
    function automatic fixed_fields_t expand_fix(input logic [7:0] t);
        fixed_fields_t f;
        f.eip       = {16'h0040, t, 8'h10};
        f.aluk      = alu_op_e'({2'b00, t[2:0]});
        f.opsize    = t[4:3];
        f.dest_addr = {24'hd00000, t};
        f.is_br     = t[7];
        return f;
    endfunction

    task automatic check_bit(input string name, input logic exp, input logic got);
        checks++;
        assert (got === exp) else begin
            value_errs++;
            $display("ERR t=%0t %s exp=%0b got=%0b", $time, name, exp, got);
        end
    endtask

    task automatic check_entry(input logic [7:0] mt, input logic [7:0] nt);
        latch_entry_t exp_e;
        exp_e.mod_part   = expand_mod(mt);
        exp_e.fixed_part = expand_fix(nt);
        checks++;
        assert (dout === exp_e) else begin
            value_errs++;
            $display("ERR t=%0t dout exp=%h got=%h", $time, exp_e, dout);
        end
    endtask

    task automatic check_slot(input logic [2:0] s, input logic [7:0] t);
        mod_fields_t exp_m;
        exp_m = expand_mod(t);
        checks++;
        assert (old_m_vector[s] === exp_m) else begin
            value_errs++;
            $display("ERR t=%0t old_m_vector[%0d] exp=%h got=%h",
                     $time, s, exp_m, old_m_vector[s]);
        end
    endtask

    // one cycle of stimulus from the parsed columns
    task automatic apply_line();
        wr          = c_wr[0];
        rd          = c_rd[0];
        clr         = c_clr[0];
        modify_mask = c_mask;
        m_din       = expand_mod(c_mt);
        n_din       = expand_fix(c_nt);
        for (int i = 0; i < queue_depth; i++) begin
            new_m_vector[i] = expand_mod(c_nv[i]);
        end
    endtask

    // state seen during this cycle, before the edge that takes the inputs
    task automatic check_line();
        check_bit("full", e_full[0], full);
        check_bit("empty", e_empty[0], empty);
        check_bit("dout_valid", e_dv[0], dout_valid);
        if (e_dv[0]) begin
            check_entry(e_mt, e_nt);
        end
        // slot column f means no vector check
        if (e_osl < queue_depth) begin
            check_slot(e_osl[2:0], e_otag);
        end
    endtask

    initial begin
        int   fd;
        int   n;
        int   guard;
        int   waited;
        int   lines_done;
        logic ready;

        checks       = 0;
        value_errs   = 0;
        other_errs   = 0;
        rst_n        = 1'b0;
        wr           = 1'b0;
        rd           = 1'b0;
        clr          = 1'b0;
        m_din        = '0;
        n_din        = '0;
        modify_mask  = '0;
        new_m_vector = '0;

        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
        end
        #1 rst_n = 1'b1;

        // idle queue expected straight out of reset
        ready  = 1'b0;
        waited = 0;
        while (!ready && waited < reset_limit) begin
            if (empty === 1'b1 && full === 1'b0 && dout_valid === 1'b0) begin
                ready = 1'b1;
            end else begin
                @(posedge clk);
                #1;
                waited++;
            end
        end
        if (!ready) begin
            other_errs++;
            $display("queue did not show an idle state after reset");
        end

        fd = $fopen("bench/queue_input.dat", "r");
        if (fd == 0) begin
            other_errs++;
            $display("could not open the stimulus file bench/queue_input.dat");
        end else begin
            guard      = 0;
            lines_done = 0;
            while (!$feof(fd) && guard < line_limit) begin
                guard++;
                line_buf = '0;
                if ($fgets(line_buf, fd) != 0) begin
                    n = $sscanf(line_buf,
                        "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        c_wr, c_rd, c_clr, c_mask, c_mt, c_nt,
                        c_nv[0], c_nv[1], c_nv[2], c_nv[3],
                        c_nv[4], c_nv[5], c_nv[6], c_nv[7],
                        e_full, e_empty, e_dv, e_mt, e_nt, e_osl, e_otag);
                    // comment and blank lines parse to nothing
                    if (n == n_cols) begin
                        @(posedge clk);
                        #1;
                        apply_line();
                        #(clk_period - 3);
                        check_line();
                        lines_done++;
                    end else if (n > 0) begin
                        other_errs++;
                        $display("data line %0d has only %0d columns", guard, n);
                    end
                end
            end
            if (!$feof(fd)) begin
                other_errs++;
                $display("timeout: stimulus file not finished after %0d lines", guard);
            end
            if (lines_done == 0) begin
                other_errs++;
                $display("stimulus file held no data lines");
            end
            $fclose(fd);
        end

        $display("checks=%0d value_errors=%0d other_errors=%0d",
                 checks, value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== mem_ex_queue.f ====
design/queue_ctrl_pkg.sv
design/latch_fields_pkg.sv
design/queue_ctrl.sv
design/mod_field_bank.sv
design/fixed_field_bank.sv
design/entry_merge.sv
design/mem_ex_queue_top.sv
bench/tb_mem_ex_queue.sv

// ==== bench/queue_input.dat ====
# wr rd clr mask m_tag n_tag new0..new7 | exp: full empty dout_valid dout_m dout_n slot old_tag
# all hex, one line per cycle, slot f skips the old_m_vector check
1 0 0 00 11 a1 00 00 00 00 00 00 00 00 0 1 0 00 00 f 00
1 0 0 00 12 a2 00 00 00 00 00 00 00 00 0 0 0 00 00 0 11
1 0 0 00 13 a3 00 00 00 00 00 00 00 00 0 0 0 00 00 1 12
1 0 0 00 14 a4 00 00 00 00 00 00 00 00 0 0 0 00 00 2 13
1 0 0 00 15 a5 00 00 00 00 00 00 00 00 0 0 0 00 00 3 14
1 0 0 00 16 a6 00 00 00 00 00 00 00 00 0 0 0 00 00 4 15
1 0 0 00 17 a7 00 00 00 00 00 00 00 00 0 0 0 00 00 5 16
1 0 0 00 18 a8 00 00 00 00 00 00 00 00 0 0 0 00 00 6 17
1 1 0 00 19 a9 00 00 00 00 00 00 00 00 1 0 0 00 00 7 18
0 1 0 00 00 00 00 00 00 00 00 00 00 00 0 0 1 11 a1 f 00
0 1 0 00 00 00 00 00 00 00 00 00 00 00 0 0 1 12 a2 f 00
0 0 0 30 00 00 00 00 00 00 54 55 00 00 0 0 1 13 a3 4 15
0 0 0 00 00 00 00 00 00 00 00 00 00 00 0 0 0 00 00 4 54
0 0 0 00 00 00 00 00 00 00 00 00 00 00 0 0 0 00 00 5 55
0 1 0 08 00 00 00 00 00 63 00 00 00 00 0 0 0 00 00 3 14
0 1 0 00 00 00 00 00 00 00 00 00 00 00 0 0 1 14 a4 3 63
0 1 0 00 00 00 00 00 00 00 00 00 00 00 0 0 1 54 a5 f 00
1 0 0 01 1a aa 70 00 00 00 00 00 00 00 0 0 1 55 a6 0 11
1 1 0 00 1b ab 00 00 00 00 00 00 00 00 0 0 0 00 00 0 1a
1 1 0 00 1c ac 00 00 00 00 00 00 00 00 0 0 1 17 a7 1 1b
0 1 0 00 00 00 00 00 00 00 00 00 00 00 0 0 1 18 a8 2 1c
0 1 0 00 00 00 00 00 00 00 00 00 00 00 0 0 1 1a aa f 00
0 1 0 00 00 00 00 00 00 00 00 00 00 00 0 0 1 1b ab f 00
0 1 0 00 00 00 00 00 00 00 00 00 00 00 0 1 1 1c ac f 00
0 0 0 00 00 00 00 00 00 00 00 00 00 00 0 1 0 00 00 f 00
1 0 0 00 1d ad 00 00 00 00 00 00 00 00 0 1 0 00 00 f 00
1 0 0 00 1e ae 00 00 00 00 00 00 00 00 0 0 0 00 00 3 1d
1 1 1 00 1f af 00 00 00 00 00 00 00 00 0 0 0 00 00 4 1e
0 1 0 00 00 00 00 00 00 00 00 00 00 00 0 1 0 00 00 5 55
0 0 0 00 00 00 00 00 00 00 00 00 00 00 0 1 0 00 00 f 00
1 0 0 00 21 b1 00 00 00 00 00 00 00 00 0 1 0 00 00 f 00
0 1 0 00 00 00 00 00 00 00 00 00 00 00 0 0 0 00 00 0 21
0 0 0 00 00 00 00 00 00 00 00 00 00 00 0 1 1 21 b1 f 00
0 0 0 00 00 00 00 00 00 00 00 00 00 00 0 1 0 00 00 f 00
